// File: common/bpu_if.sv
//----------------------------------------------------------
// Branch predictor lookup and update
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

interface bpu_if;

   // Lookup for the word on the bus
   logic                 lkp_valid;
   logic [`FETCH_AW-3:0] lkp_pc;
   logic                 lkp_taken;

   // Resolved outcome from later stages
   logic                 upd_valid;
   logic [`FETCH_AW-3:0] upd_pc;
   logic                 upd_taken;

   modport fetch (
      output lkp_valid,
      output lkp_pc,
      input  lkp_taken
   );

   modport tbl (
      input  lkp_valid,
      input  lkp_pc,
      output lkp_taken,
      input  upd_valid,
      input  upd_pc,
      input  upd_taken
   );

   modport upd (
      output upd_valid,
      output upd_pc,
      output upd_taken
   );

endinterface

// File: common/fetch_defs.svh
//----------------------------------------------------------
// Fetch front end widths and vectors
//----------------------------------------------------------
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Byte address width, word PCs drop the low two bits
`define FETCH_AW 32

// Instruction word width
`define FETCH_IW 32

// log2 of the branch history table depth
`define FETCH_BHT_BITS 4

// Exception entry points, as word addresses
`define FETCH_RST_VECTOR 0
`define FETCH_SYSCALL_VECTOR 8

// Cycles after reset before the instruction bus is accepted
`define FETCH_WARMUP 2

`endif

// File: common/fetch_pkg.sv
//----------------------------------------------------------
// Fetch opcode and instruction types
//----------------------------------------------------------
package fetch_pkg;

   // Major opcodes seen by the predecoder
   typedef enum logic [5:0] {
      OP_OTHER   = 6'h00,
      OP_JMPREL  = 6'h01,
      OP_BCC     = 6'h02,
      OP_BT      = 6'h03,
      OP_JMPFAR  = 6'h04,
      OP_SYSCALL = 6'h05,
      OP_RET     = 6'h06
   } opcode_t;

   // Relative jumps and branches, signed word offset
   typedef struct packed {
      opcode_t     opcode;
      logic        link;
      logic [24:0] offset;
   } insn_rel_t;

   // Absolute jump, zero-extended word target
   typedef struct packed {
      opcode_t     opcode;
      logic [25:0] target;
   } insn_abs_t;

   // Same 32-bit word, two views
   typedef union packed {
      insn_rel_t rel;
      insn_abs_t abs;
   } insn_t;

endpackage

// File: fetch/fetch_ctrl.sv
//----------------------------------------------------------
// Fetch warm-up control
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic buf_ready,
   output logic ibus_ready
);

   localparam int CW = $clog2(`FETCH_WARMUP + 1);

   typedef enum logic {
      WARMUP = 1'b0,
      RUN    = 1'b1
   } state_t;

   state_t        state;
   state_t        state_nxt;
   logic [CW-1:0] cnt;
   logic          cnt_done;

   assign cnt_done = (cnt == CW'(`FETCH_WARMUP - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         WARMUP: if (cnt_done) state_nxt = RUN;
         RUN:    state_nxt = RUN;
         default: state_nxt = WARMUP;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= WARMUP;
      end else begin
         state <= state_nxt;
      end
   end

   // Counts only while warming up
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (state == WARMUP && !cnt_done) begin
         cnt <= cnt + 1'b1;
      end
   end

   // Accept words only in RUN with room downstream
   assign ibus_ready = (state == RUN) & buf_ready;

   // Bus opens only once the warm-up count is complete
   a_no_ready_warmup: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_ready |-> cnt_done);

endmodule

// File: fetch/fetch_unit.sv
//----------------------------------------------------------
// Next PC and decoder-side capture
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cas,
   input  logic [`FETCH_IW-1:0] ibus_insn,
   input  logic [`FETCH_AW-1:0] ibus_id,
   output logic [`FETCH_AW-1:0] ibus_addr,
   input  logic                 flush,
   input  logic [`FETCH_AW-3:0] flush_tgt,
   input  logic [`FETCH_AW-3:0] epc,
   bpu_if.fetch                 bpu,
   output logic [`FETCH_IW-1:0] idu_insn,
   output logic [`FETCH_AW-3:0] idu_pc,
   output logic                 idu_op_jmprel,
   output logic                 idu_jmprel_link,
   output logic                 idu_op_jmpfar,
   output logic                 idu_op_syscall,
   output logic                 idu_op_ret,
   output logic [`FETCH_AW-3:0] idu_specul_tgt,
   output logic                 idu_specul_bcc
);

   localparam int PW = `FETCH_AW - 2;

   insn_t           insn;
   logic            op_jmprel;
   logic            jmprel_link;
   logic            op_bcc;
   logic            op_bt;
   logic            op_jmpfar;
   logic            op_syscall;
   logic            op_ret;
   logic [PW-1:0]   rel_offset;
   logic [PW-1:0]   far_tgt;
   logic [PW-1:0]   pc;
   logic [PW-1:0]   pc_inc;
   logic [PW-1:0]   rel_tgt;
   logic [PW-1:0]   jmprel_tgt;
   logic [PW-1:0]   next_pc;
   logic [PW-1:0]   specul_tgt_nxt;
   logic            rel_taken;
   logic            specul_bcc_nxt;
   logic            keep;

   assign insn = ibus_insn;

   predecoder predecoder_i (
      .insn        (insn),
      .op_jmprel   (op_jmprel),
      .jmprel_link (jmprel_link),
      .op_bcc      (op_bcc),
      .op_bt       (op_bt),
      .op_jmpfar   (op_jmpfar),
      .op_syscall  (op_syscall),
      .op_ret      (op_ret),
      .rel_offset  (rel_offset),
      .far_tgt     (far_tgt)
   );

   assign pc     = ibus_id[`FETCH_AW-1:2];
   assign pc_inc = pc + 1'b1;
   assign rel_tgt = pc + rel_offset;

   // Only conditional branches ask the predictor
   assign bpu.lkp_valid = op_bcc;
   assign bpu.lkp_pc    = pc;

   // Unconditional jmprel is always taken
   assign rel_taken  = op_jmprel & (~op_bcc | bpu.lkp_taken);
   assign jmprel_tgt = rel_taken ? rel_tgt : pc_inc;

   // Priority mux, flush first
   assign next_pc = flush      ? flush_tgt
                  : op_syscall ? PW'(`FETCH_SYSCALL_VECTOR)
                  : op_ret     ? epc
                  : op_jmpfar  ? far_tgt
                  : op_jmprel  ? jmprel_tgt
                  : pc_inc;

   assign ibus_addr = {next_pc, 2'b00};

   // Alternate path for a wrong guess on branches
   assign specul_tgt_nxt = op_bcc    ? (bpu.lkp_taken ? pc_inc : rel_tgt)
                         : op_jmpfar ? far_tgt
                         : op_ret    ? epc
                         : '0;

   // Condition flag the prediction assumes
   assign specul_bcc_nxt = (op_bt & bpu.lkp_taken) | (op_bcc & ~op_bt & ~bpu.lkp_taken);

   assign keep = ~flush;

   // Control path, squashed on flush
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idu_insn        <= '0;
         idu_op_jmprel   <= 1'b0;
         idu_jmprel_link <= 1'b0;
         idu_op_jmpfar   <= 1'b0;
         idu_op_syscall  <= 1'b0;
         idu_op_ret      <= 1'b0;
      end else if (cas) begin
         idu_insn        <= ibus_insn & {`FETCH_IW{keep}};
         idu_op_jmprel   <= op_jmprel & keep;
         idu_jmprel_link <= jmprel_link & keep;
         idu_op_jmpfar   <= op_jmpfar & keep;
         idu_op_syscall  <= op_syscall & keep;
         idu_op_ret      <= op_ret & keep;
      end
   end

   // Data path
   always_ff @(posedge clk) begin
      if (cas) begin
         idu_pc         <= pc;
         idu_specul_tgt <= specul_tgt_nxt;
         idu_specul_bcc <= specul_bcc_nxt;
      end
   end

   a_far_rel_mutex: assert property (@(posedge clk) disable iff (!rst_n)
      cas |-> !(op_jmpfar && op_jmprel));

endmodule

// File: fetch/predecoder.sv
//----------------------------------------------------------
// Instruction predecoder
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

module predecoder import fetch_pkg::*; (
   input  insn_t                insn,
   output logic                 op_jmprel,
   output logic                 jmprel_link,
   output logic                 op_bcc,
   output logic                 op_bt,
   output logic                 op_jmpfar,
   output logic                 op_syscall,
   output logic                 op_ret,
   output logic [`FETCH_AW-3:0] rel_offset,
   output logic [`FETCH_AW-3:0] far_tgt
);

   localparam int PW = `FETCH_AW - 2;

   opcode_t opc;

   // Opcode sits in the same bits for both formats
   assign opc = insn.rel.opcode;

   always_comb begin
      op_jmprel   = 1'b0;
      jmprel_link = 1'b0;
      op_bcc      = 1'b0;
      op_bt       = 1'b0;
      op_jmpfar   = 1'b0;
      op_syscall  = 1'b0;
      op_ret      = 1'b0;
      case (opc)
         OP_JMPREL: begin
            op_jmprel   = 1'b1;
            jmprel_link = insn.rel.link;
         end
         // Both branch kinds are relative jumps
         OP_BCC: begin
            op_jmprel = 1'b1;
            op_bcc    = 1'b1;
         end
         OP_BT: begin
            op_jmprel = 1'b1;
            op_bcc    = 1'b1;
            op_bt     = 1'b1;
         end
         OP_JMPFAR:  op_jmpfar = 1'b1;
         OP_SYSCALL: op_syscall = 1'b1;
         OP_RET:     op_ret = 1'b1;
         default: begin
         end
      endcase
   end

   // Signed word offset
   assign rel_offset = {{(PW-25){insn.rel.offset[24]}}, insn.rel.offset};

   // Absolute view, zero extended
   assign far_tgt = {{(PW-26){1'b0}}, insn.abs.target};

endmodule

// File: fetch_top.f
+incdir+common
common/fetch_pkg.sv
common/bpu_if.sv
fetch/predecoder.sv
fetch/fetch_ctrl.sv
fetch/fetch_unit.sv
hdl/branch_history.sv
hdl/pipe_buf.sv
hdl/fetch_top.sv
verif/fetch_tb.sv

// File: hdl/branch_history.sv
//----------------------------------------------------------
// Branch history table
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

module branch_history (
   input  logic clk,
   input  logic rst_n,
   bpu_if.tbl   bpu
);

   localparam int DEPTH = 1 << `FETCH_BHT_BITS;

   logic [1:0]                  cnt [DEPTH];
   logic [`FETCH_BHT_BITS-1:0]  lkp_idx;
   logic [`FETCH_BHT_BITS-1:0]  upd_idx;

   assign lkp_idx = bpu.lkp_pc[`FETCH_BHT_BITS-1:0];
   assign upd_idx = bpu.upd_pc[`FETCH_BHT_BITS-1:0];

   // Taken when the counter MSB is set
   assign bpu.lkp_taken = bpu.lkp_valid & cnt[lkp_idx][1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Weakly not taken
         for (int i = 0; i < DEPTH; i++) begin
            cnt[i] <= 2'd1;
         end
      end else if (bpu.upd_valid) begin
         if (bpu.upd_taken && cnt[upd_idx] != 2'd3) begin
            cnt[upd_idx] <= cnt[upd_idx] + 2'd1;
         end else if (!bpu.upd_taken && cnt[upd_idx] != 2'd0) begin
            cnt[upd_idx] <= cnt[upd_idx] - 2'd1;
         end
      end
   end

   a_upd_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
      bpu.upd_valid |-> !$isunknown(upd_idx));

endmodule

// File: hdl/fetch_top.sv
//----------------------------------------------------------
// Instruction fetch front end
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 ibus_valid,
   output logic                 ibus_ready,
   output logic [`FETCH_AW-1:0] ibus_addr,
   input  logic [`FETCH_IW-1:0] ibus_insn,
   input  logic [`FETCH_AW-1:0] ibus_id,
   input  logic                 flush,
   input  logic [`FETCH_AW-3:0] flush_tgt,
   input  logic [`FETCH_AW-3:0] epc,
   input  logic                 bpu_upd_valid,
   input  logic [`FETCH_AW-3:0] bpu_upd_pc,
   input  logic                 bpu_upd_taken,
   input  logic                 idu_ready,
   output logic                 idu_valid,
   output logic [`FETCH_IW-1:0] idu_insn,
   output logic [`FETCH_AW-3:0] idu_pc,
   output logic                 idu_op_jmprel,
   output logic                 idu_jmprel_link,
   output logic                 idu_op_jmpfar,
   output logic                 idu_op_syscall,
   output logic                 idu_op_ret,
   output logic [`FETCH_AW-3:0] idu_specul_tgt,
   output logic                 idu_specul_bcc
);

   logic buf_ready;
   logic cas;

   bpu_if bpu_i ();

   assign bpu_i.upd_valid = bpu_upd_valid;
   assign bpu_i.upd_pc    = bpu_upd_pc;
   assign bpu_i.upd_taken = bpu_upd_taken;

   fetch_ctrl fetch_ctrl_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .buf_ready  (buf_ready),
      .ibus_ready (ibus_ready)
   );

   // Only real bus transfers enter the stage
   pipe_buf pipe_buf_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (ibus_valid & ibus_ready),
      .in_ready  (buf_ready),
      .out_valid (idu_valid),
      .out_ready (idu_ready),
      .cas       (cas)
   );

   fetch_unit fetch_unit_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .cas             (cas),
      .ibus_insn       (ibus_insn),
      .ibus_id         (ibus_id),
      .ibus_addr       (ibus_addr),
      .flush           (flush),
      .flush_tgt       (flush_tgt),
      .epc             (epc),
      .bpu             (bpu_i.fetch),
      .idu_insn        (idu_insn),
      .idu_pc          (idu_pc),
      .idu_op_jmprel   (idu_op_jmprel),
      .idu_jmprel_link (idu_jmprel_link),
      .idu_op_jmpfar   (idu_op_jmpfar),
      .idu_op_syscall  (idu_op_syscall),
      .idu_op_ret      (idu_op_ret),
      .idu_specul_tgt  (idu_specul_tgt),
      .idu_specul_bcc  (idu_specul_bcc)
   );

   branch_history branch_history_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bpu   (bpu_i.tbl)
   );

endmodule

// File: hdl/pipe_buf.sv
//----------------------------------------------------------
// One-entry valid/ready stage
//----------------------------------------------------------
`timescale 1ns/1ns

module pipe_buf (
   input  logic clk,
   input  logic rst_n,
   input  logic in_valid,
   output logic in_ready,
   output logic out_valid,
   input  logic out_ready,
   output logic cas
);

   logic full;

   // Room when empty or emptying this cycle
   assign in_ready = ~full | out_ready;

   // Load strobe for the payload registers
   assign cas = in_valid & in_ready;

   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (cas) begin
         full <= 1'b1;
      end else if (out_ready) begin
         full <= 1'b0;
      end
   end

   a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid);

endmodule

// File: verif/fetch_tb.sv
//----------------------------------------------------------
// Fetch front end testbench
//----------------------------------------------------------
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_tb import fetch_pkg::*;;

   localparam int NROWS          = 32;
   localparam int RST_CYCLES     = 8;
   localparam int TIMEOUT_CYCLES = 4 * NROWS + 50;

   typedef struct {
      logic [31:0] insn;
      logic [31:0] id;
      logic        valid;
      logic        flush;
      logic [29:0] ftgt;
      logic [29:0] epc;
      logic [1:0]  rdy;
      logic        uv;
      logic [29:0] upc;
      logic        ut;
   } row_t;

   typedef struct {
      logic [31:0] insn;
      logic [29:0] pc;
      logic        jmprel;
      logic        link;
      logic        jmpfar;
      logic        syscall;
      logic        ret;
      logic [29:0] tgt;
      logic        bcc;
   } item_t;

   logic        clk;
   logic        rst_n;
   logic        ibus_valid;
   logic        ibus_ready;
   logic [31:0] ibus_addr;
   logic [31:0] ibus_insn;
   logic [31:0] ibus_id;
   logic        flush;
   logic [29:0] flush_tgt;
   logic [29:0] epc;
   logic        bpu_upd_valid;
   logic [29:0] bpu_upd_pc;
   logic        bpu_upd_taken;
   logic        idu_ready;
   logic        idu_valid;
   logic [31:0] idu_insn;
   logic [29:0] idu_pc;
   logic        idu_op_jmprel;
   logic        idu_jmprel_link;
   logic        idu_op_jmpfar;
   logic        idu_op_syscall;
   logic        idu_op_ret;
   logic [29:0] idu_specul_tgt;
   logic        idu_specul_bcc;

   row_t        rows [NROWS];
   int          nrows;
   item_t       exp_q [$];
   logic [1:0]  ctr [16];
   int          errors;
   int          checks;
   int          timeout_cnt;
   integer      seed;
   logic        stalled;
   logic [31:0] hold_insn;
   logic [29:0] hold_pc;
   logic [29:0] hold_tgt;
   logic        accepted;

   fetch_top dut_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .ibus_valid      (ibus_valid),
      .ibus_ready      (ibus_ready),
      .ibus_addr       (ibus_addr),
      .ibus_insn       (ibus_insn),
      .ibus_id         (ibus_id),
      .flush           (flush),
      .flush_tgt       (flush_tgt),
      .epc             (epc),
      .bpu_upd_valid   (bpu_upd_valid),
      .bpu_upd_pc      (bpu_upd_pc),
      .bpu_upd_taken   (bpu_upd_taken),
      .idu_ready       (idu_ready),
      .idu_valid       (idu_valid),
      .idu_insn        (idu_insn),
      .idu_pc          (idu_pc),
      .idu_op_jmprel   (idu_op_jmprel),
      .idu_jmprel_link (idu_jmprel_link),
      .idu_op_jmpfar   (idu_op_jmpfar),
      .idu_op_syscall  (idu_op_syscall),
      .idu_op_ret      (idu_op_ret),
      .idu_specul_tgt  (idu_specul_tgt),
      .idu_specul_bcc  (idu_specul_bcc)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Relative format word
   function automatic logic [31:0] rel_word(input opcode_t op, input int link, input int off);
      insn_t w;
      w.rel.opcode = op;
      w.rel.link   = link[0];
      w.rel.offset = off[24:0];
      return w;
   endfunction

   // Absolute format word
   function automatic logic [31:0] abs_word(input opcode_t op, input int tgt);
      insn_t w;
      w.abs.opcode = op;
      w.abs.target = tgt[25:0];
      return w;
   endfunction

   task automatic add_row(input logic [31:0] word, input logic [31:0] id, input int valid,
                          input int fl, input int ftgt, input int ep, input int rdy,
                          input int uv, input int upc, input int ut);
      rows[nrows].insn  = word;
      rows[nrows].id    = id;
      rows[nrows].valid = valid[0];
      rows[nrows].flush = fl[0];
      rows[nrows].ftgt  = ftgt[29:0];
      rows[nrows].epc   = ep[29:0];
      rows[nrows].rdy   = rdy[1:0];
      rows[nrows].uv    = uv[0];
      rows[nrows].upc   = upc[29:0];
      rows[nrows].ut    = ut[0];
      nrows++;
   endtask

   // rdy column: 0 stall, 1 ready, 2 random
   task automatic load_table();
      logic [31:0] w;
      nrows = 0;
      add_row(rel_word(OP_OTHER, 0, 'h123), 32'h000, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_OTHER, 0, 'h55), 32'h004, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_JMPREL, 0, 5), 32'h008, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_JMPREL, 1, -3), 32'h01C, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(abs_word(OP_JMPFAR, 'h100), 32'h010, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_RET, 0, 0), 32'h400, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_SYSCALL, 0, 0), 32'h100, 1, 0, 0, 'h40, 1, 0, 0, 0);
      // Untrained branches fall through
      add_row(rel_word(OP_BT, 0, 16), 32'h020, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_BCC, 0, 4), 32'h024, 1, 0, 0, 'h40, 1, 0, 0, 0);
      // Two taken updates per branch PC
      add_row(rel_word(OP_OTHER, 0, 1), 32'h028, 1, 0, 0, 'h40, 1, 1, 8, 1);
      add_row(rel_word(OP_OTHER, 0, 2), 32'h02C, 1, 0, 0, 'h40, 1, 1, 8, 1);
      add_row(rel_word(OP_OTHER, 0, 3), 32'h030, 1, 0, 0, 'h40, 1, 1, 9, 1);
      add_row(rel_word(OP_OTHER, 0, 4), 32'h034, 1, 0, 0, 'h40, 1, 1, 9, 1);
      add_row(rel_word(OP_BT, 0, 16), 32'h020, 1, 0, 0, 'h40, 1, 0, 0, 0);
      add_row(rel_word(OP_BCC, 0, 4), 32'h024, 1, 0, 0, 'h40, 1, 0, 0, 0);
      // Flush squashes the captured word
      add_row(rel_word(OP_OTHER, 0, 9), 32'h038, 1, 1, 'h200, 'h40, 1, 0, 0, 0);
      add_row(abs_word(OP_JMPFAR, 'h300), 32'h800, 1, 1, 'h50, 'h40, 1, 0, 0, 0);
      // Back-pressure from the decoder
      add_row(rel_word(OP_OTHER, 0, 6), 32'h140, 1, 0, 0, 'h40, 0, 0, 0, 0);
      add_row(rel_word(OP_OTHER, 0, 7), 32'h144, 1, 0, 0, 'h40, 0, 0, 0, 0);
      add_row(32'h0, 32'h0, 0, 0, 0, 'h40, 0, 0, 0, 0);
      add_row(32'h0, 32'h0, 0, 0, 0, 'h40, 0, 0, 0, 0);
      add_row(32'h0, 32'h0, 0, 0, 0, 'h40, 1, 0, 0, 0);
      for (int k = 0; k < 10; k++) begin
         case (k % 4)
            0: w = rel_word(OP_OTHER, 0, k);
            1: w = rel_word(OP_JMPREL, (k >> 2) & 1, k + 2);
            2: w = rel_word(OP_BCC, 0, -k);
            default: w = abs_word(OP_JMPFAR, 'h80 + k);
         endcase
         add_row(w, 32'h180 + 32'(k * 4), int'(k != 6), 0, 0, 'h44, 2, 0, 0, 0);
      end
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Expected next PC and decoder item for the presented word
   task automatic model_fetch(input logic [31:0] word, input logic [31:0] id, input logic fl,
                              input logic [29:0] ftgt, input logic [29:0] ep,
                              output logic [29:0] next_pc, output item_t it);
      insn_t       w;
      logic [29:0] pc;
      logic [29:0] off;
      logic [29:0] far;
      logic        is_br;
      logic        taken;
      w     = word;
      pc    = id[31:2];
      off   = {{5{word[24]}}, word[24:0]};
      far   = {4'b0, word[25:0]};
      is_br = (w.rel.opcode == OP_BCC) || (w.rel.opcode == OP_BT);
      taken = is_br && (ctr[pc[3:0]] >= 2'd2);
      if (fl) next_pc = ftgt;
      else if (w.rel.opcode == OP_SYSCALL) next_pc = 30'(`FETCH_SYSCALL_VECTOR);
      else if (w.rel.opcode == OP_RET) next_pc = ep;
      else if (w.rel.opcode == OP_JMPFAR) next_pc = far;
      else if (w.rel.opcode == OP_JMPREL || taken) next_pc = pc + off;
      else next_pc = pc + 30'd1;
      it.insn    = fl ? 32'h0 : word;
      it.pc      = pc;
      // Branches are predecoded as relative jumps
      it.jmprel  = !fl && (w.rel.opcode == OP_JMPREL || is_br);
      it.link    = !fl && (w.rel.opcode == OP_JMPREL) && word[25];
      it.jmpfar  = !fl && (w.rel.opcode == OP_JMPFAR);
      it.syscall = !fl && (w.rel.opcode == OP_SYSCALL);
      it.ret     = !fl && (w.rel.opcode == OP_RET);
      if (is_br) it.tgt = taken ? pc + 30'd1 : pc + off;
      else if (w.rel.opcode == OP_JMPFAR) it.tgt = far;
      else if (w.rel.opcode == OP_RET) it.tgt = ep;
      else it.tgt = 30'h0;
      it.bcc = (w.rel.opcode == OP_BT && taken) || (w.rel.opcode == OP_BCC && !taken);
   endtask

   task automatic train_counter(input logic [29:0] pc, input logic taken);
      if (taken && ctr[pc[3:0]] != 2'd3) ctr[pc[3:0]] = ctr[pc[3:0]] + 2'd1;
      else if (!taken && ctr[pc[3:0]] != 2'd0) ctr[pc[3:0]] = ctr[pc[3:0]] - 2'd1;
   endtask

   task automatic check_item(input item_t e);
      check_eq("idu_insn", idu_insn, e.insn);
      check_eq("idu_pc", 32'(idu_pc), 32'(e.pc));
      check_eq("idu_op_jmprel", 32'(idu_op_jmprel), 32'(e.jmprel));
      check_eq("idu_jmprel_link", 32'(idu_jmprel_link), 32'(e.link));
      check_eq("idu_op_jmpfar", 32'(idu_op_jmpfar), 32'(e.jmpfar));
      check_eq("idu_op_syscall", 32'(idu_op_syscall), 32'(e.syscall));
      check_eq("idu_op_ret", 32'(idu_op_ret), 32'(e.ret));
      check_eq("idu_specul_tgt", 32'(idu_specul_tgt), 32'(e.tgt));
      check_eq("idu_specul_bcc", 32'(idu_specul_bcc), 32'(e.bcc));
   endtask

   // Runs at the falling edge, when all inputs and outputs are settled
   task automatic observe_cycle();
      item_t       exp_item;
      item_t       front;
      logic [29:0] exp_next;
      model_fetch(ibus_insn, ibus_id, flush, flush_tgt, epc, exp_next, exp_item);
      if (ibus_valid) check_eq("ibus_addr", ibus_addr, {exp_next, 2'b00});
      check_eq("ibus_ready", 32'(ibus_ready), 32'(!idu_valid || idu_ready));
      check_eq("idu_valid", 32'(idu_valid), 32'(exp_q.size() != 0));
      if (stalled) begin
         check_eq("idu_insn", idu_insn, hold_insn);
         check_eq("idu_pc", 32'(idu_pc), 32'(hold_pc));
         check_eq("idu_specul_tgt", 32'(idu_specul_tgt), 32'(hold_tgt));
      end
      if (idu_valid && idu_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Decoder transfer at %0t ns with no item expected", $time);
         end else begin
            front = exp_q.pop_front();
            check_item(front);
         end
      end
      if (ibus_valid && ibus_ready) exp_q.push_back(exp_item);
      if (bpu_upd_valid) train_counter(bpu_upd_pc, bpu_upd_taken);
      stalled   = idu_valid && !idu_ready;
      hold_insn = idu_insn;
      hold_pc   = idu_pc;
      hold_tgt  = idu_specul_tgt;
   endtask

   // Called just after a rising edge
   task automatic drive_row(input int r, input bit first);
      integer rnd;
      rnd = $random(seed);
      ibus_insn     <= rows[r].insn;
      ibus_id       <= rows[r].id;
      ibus_valid    <= rows[r].valid;
      flush         <= rows[r].flush;
      flush_tgt     <= rows[r].ftgt;
      epc           <= rows[r].epc;
      bpu_upd_valid <= rows[r].uv & first;
      bpu_upd_pc    <= rows[r].upc;
      bpu_upd_taken <= rows[r].ut;
      // A repeated row always lets the stage drain
      if (!first) idu_ready <= 1'b1;
      else if (rows[r].rdy == 2'd2) idu_ready <= rnd[0];
      else idu_ready <= rows[r].rdy[0];
   endtask

   initial begin
      timeout_cnt = 0;
      while (timeout_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         timeout_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
   end

   initial begin
      rst_n         = 1'b0;
      ibus_valid    = 1'b0;
      ibus_insn     = 32'h0;
      ibus_id       = 32'h0;
      flush         = 1'b0;
      flush_tgt     = 30'h0;
      epc           = 30'h0;
      bpu_upd_valid = 1'b0;
      bpu_upd_pc    = 30'h0;
      bpu_upd_taken = 1'b0;
      idu_ready     = 1'b0;
      errors        = 0;
      checks        = 0;
      stalled       = 1'b0;
      seed          = 32'h7881_8679;
      for (int i = 0; i < 16; i++) ctr[i] = 2'd1;
      load_table();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      // Bus stays closed during warm-up
      repeat (`FETCH_WARMUP) begin
         @(negedge clk);
         check_eq("ibus_ready", 32'(ibus_ready), 32'h0);
         check_eq("idu_valid", 32'(idu_valid), 32'h0);
      end
      @(negedge clk);
      check_eq("ibus_ready", 32'(ibus_ready), 32'h1);
      for (int r = 0; r < nrows; r++) begin
         bit first;
         first = 1'b1;
         do begin
            @(posedge clk);
            drive_row(r, first);
            @(negedge clk);
            accepted = !ibus_valid || ibus_ready;
            observe_cycle();
            first = 1'b0;
         end while (!accepted);
      end
      while (exp_q.size() != 0) begin
         @(posedge clk);
         ibus_valid    <= 1'b0;
         flush         <= 1'b0;
         bpu_upd_valid <= 1'b0;
         idu_ready     <= 1'b1;
         @(negedge clk);
         observe_cycle();
      end
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
